// File: include/video_rx_cfg.svh
// word layout and sizing for the video receive pipe, included by packages and modules
`ifndef VIDEO_RX_CFG_SVH
`define VIDEO_RX_CFG_SVH

// fifo word and depth
`define VIDEO_DATA_SIZE  140
`define VIDEO_FIFO_AW    4

// aggregators behind the ack decode
`define VIDEO_AGGR_NUM   4

// flag nibble {data_en, short_en, footer_en, header_en}, bits 139:136 reserved
`define VIDEO_FLAG_MSB   135
`define VIDEO_FLAG_LSB   132

// header and short word fields
`define VIDEO_DT_MSB     131
`define VIDEO_DT_LSB     126
`define VIDEO_SHORT_BIT  125

`define VIDEO_PAYLOAD_W  128
`define VIDEO_LCRC_W     32

`endif

// File: rtl/video_pkt_pkg.sv
// packet word format of the receive pipe, imported by the read controller and the crc check
`default_nettype none

`include "video_rx_cfg.svh"

package video_pkt_pkg;

   // csi data types seen in header and short words
   typedef enum logic [5:0] {
      FRAME_START = 6'h00,
      FRAME_END   = 6'h01,
      LINE_START  = 6'h02,
      LINE_END    = 6'h03,
      RAW8        = 6'h2A
   } csi_dt_e;

   // {data_en, short_en, footer_en, header_en}
   typedef logic [3:0] pkt_flag_t;

   localparam pkt_flag_t FLAGS_DATA   = 4'b1000;
   localparam pkt_flag_t FLAGS_SHORT  = 4'b0100;
   localparam pkt_flag_t FLAGS_FOOTER = 4'b0010;
   localparam pkt_flag_t FLAGS_HEADER = 4'b0001;
   // line crc word carries no flag at all
   localparam pkt_flag_t FLAGS_CRC    = 4'b0000;

   function automatic pkt_flag_t pkt_flags(input logic [`VIDEO_DATA_SIZE-1:0] word);
      return word[`VIDEO_FLAG_MSB:`VIDEO_FLAG_LSB];
   endfunction

   // short packet only carries frame/line sync types
   function automatic logic is_short_pkt(input logic [`VIDEO_DATA_SIZE-1:0] word);
      return (pkt_flags(word) == FLAGS_SHORT) &&
             (word[`VIDEO_DT_MSB:`VIDEO_DT_LSB] <= LINE_END);
   endfunction

   function automatic logic [`VIDEO_PAYLOAD_W-1:0] pkt_payload(
      input logic [`VIDEO_DATA_SIZE-1:0] word);
      return word[`VIDEO_PAYLOAD_W-1:0];
   endfunction

   function automatic logic [`VIDEO_LCRC_W-1:0] pkt_lcrc(input logic [`VIDEO_DATA_SIZE-1:0] word);
      return word[`VIDEO_LCRC_W-1:0];
   endfunction

endpackage

`default_nettype wire

// File: rtl/video_rx_ctrl_pkg.sv
// read controller state encoding, imported by the controller and used in the top-level ports
`default_nettype none

package video_rx_ctrl_pkg;

   typedef enum logic [2:0] {
      RX_SILENT   = 3'd0,
      RX_IDLE     = 3'd1,
      RX_SHORT    = 3'd2,
      RX_HEADER   = 3'd3,
      RX_DATA     = 3'd4,
      RX_FOOTER   = 3'd5,
      RX_LINE_CRC = 3'd6,
      RX_LINE_END = 3'd7
   } rx_state_e;

   // states entered by popping the head word
   function automatic logic rx_consumes(input rx_state_e st);
      return st inside {RX_SHORT, RX_HEADER, RX_DATA, RX_FOOTER, RX_LINE_CRC};
   endfunction

endpackage

`default_nettype wire

// File: rtl/video_line_fifo.sv
// line fifo holding packet words ahead of the read controller, head word shown without a read
`timescale 1ns/1ps
`default_nettype none

`include "video_rx_cfg.svh"

module video_line_fifo (
   input  logic                        fifo_rdclk,
   input  logic                        fifo_rdclk_rst_n,
   input  logic                        wr_en,
   input  logic [`VIDEO_DATA_SIZE-1:0] wr_data,
   input  logic                        rd_en,
   output logic [`VIDEO_DATA_SIZE-1:0] rdata,
   output logic                        empty,
   output logic                        full
);

   localparam int AW    = `VIDEO_FIFO_AW;
   localparam int DEPTH = 1 << AW;

   logic [`VIDEO_DATA_SIZE-1:0] mem [0:DEPTH-1];
   logic [AW:0]                 wr_ptr;
   logic [AW:0]                 rd_ptr;
   logic                        do_wr;
   logic                        do_rd;

   // extra msb tells full from empty
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   assign do_rd = rd_en && !empty;
   // a slot frees up on the same edge when full and popping
   assign do_wr = wr_en && (!full || do_rd);

   assign rdata = mem[rd_ptr[AW-1:0]];

   always_ff @(posedge fifo_rdclk) begin
      if (do_wr) begin
         mem[wr_ptr[AW-1:0]] <= wr_data;
      end
   end

   always_ff @(posedge fifo_rdclk or negedge fifo_rdclk_rst_n) begin
      if (!fifo_rdclk_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   a_no_pop_empty : assert property (@(posedge fifo_rdclk) disable iff (!fifo_rdclk_rst_n)
      empty |-> !rd_en);

   // writer must never overrun, only a same-edge pop makes room
   a_no_push_full : assert property (@(posedge fifo_rdclk) disable iff (!fifo_rdclk_rst_n)
      (full && wr_en) |-> rd_en);

endmodule

`default_nettype wire

// File: rtl/video_fifo_rd_ctrl.sv
// packet read controller, drains the line fifo under the rx state machine and drives ack
`timescale 1ns/1ps
`default_nettype none

`include "video_rx_cfg.svh"

module video_fifo_rd_ctrl (
   input  logic                               fifo_rdclk,
   input  logic                               fifo_rdclk_rst_n,
   input  logic                               up_state,
   input  logic                               fifo_empty,
   input  logic [`VIDEO_DATA_SIZE-1:0]        fifo_rdata,
   input  logic                               empty_depend_cnt_mux,
   input  logic                               pkt_crc_gen_dis,
   input  logic                               pipe_mem_clear,
   input  logic [3:0]                         pkt_aggr_id,
   input  logic                               pkt_aggr_id_vld,
   output logic                               fifo_rd,
   output logic [`VIDEO_DATA_SIZE-1:0]        video_data,
   output logic                               video_data_vld,
   output video_rx_ctrl_pkg::rx_state_e       current_state,
   output logic                               ack,
   output logic                               ack_pre,
   output logic [`VIDEO_AGGR_NUM-1:0]         ack_vld_aggregator,
   output logic                               line_end
);

   import video_pkt_pkg::*;
   import video_rx_ctrl_pkg::*;

   pkt_flag_t flags;
   logic      sp_pkt;
   logic      lp_hdr_pkt;
   logic      lp_footer_pkt;
   logic      lp_payload_pkt;
   logic      lp_crc_pkt;
   rx_state_e next_state;
   logic      fifo_rd_norm;
   logic      fifo_rd_junk;

   // head word classification
   assign flags          = pkt_flags(fifo_rdata);
   assign sp_pkt         = is_short_pkt(fifo_rdata);
   assign lp_hdr_pkt     = (flags == FLAGS_HEADER);
   // data_en is a don't care on the footer
   assign lp_footer_pkt  = ((flags & 4'b0111) == FLAGS_FOOTER);
   assign lp_payload_pkt = ((flags & 4'b1101) == FLAGS_DATA);
   assign lp_crc_pkt     = (flags == FLAGS_CRC);

   always_ff @(posedge fifo_rdclk or negedge fifo_rdclk_rst_n) begin
      if (!fifo_rdclk_rst_n) begin
         current_state <= RX_SILENT;
      end else begin
         current_state <= next_state;
      end
   end

   always_comb begin
      next_state = current_state;
      case (current_state)
         RX_SILENT: begin
            if (up_state) begin
               next_state = RX_IDLE;
            end
         end
         RX_IDLE: begin
            if (!fifo_empty && sp_pkt) begin
               next_state = RX_SHORT;
            end else if (!fifo_empty && lp_hdr_pkt) begin
               next_state = RX_HEADER;
            end
         end
         RX_SHORT: begin
            next_state = empty_depend_cnt_mux ? RX_LINE_END : RX_IDLE;
         end
         RX_HEADER, RX_DATA: begin
            // an empty fifo after the header still advances
            if (fifo_empty) begin
               next_state = RX_DATA;
            end else if (lp_footer_pkt) begin
               next_state = RX_FOOTER;
            end else if (lp_payload_pkt) begin
               next_state = RX_DATA;
            end else begin
               next_state = RX_IDLE;
            end
         end
         RX_FOOTER: begin
            if (pkt_crc_gen_dis) begin
               next_state = RX_LINE_END;
            end else if (!fifo_empty) begin
               next_state = lp_crc_pkt ? RX_LINE_CRC : RX_IDLE;
            end
         end
         RX_LINE_CRC: begin
            next_state = RX_LINE_END;
         end
         RX_LINE_END: begin
            next_state = RX_SILENT;
         end
         default: begin
            next_state = RX_IDLE;
         end
      endcase
   end

   // junk: flush request, or anything in idle that starts no packet
   assign fifo_rd_junk = !fifo_empty &&
                         (pipe_mem_clear ||
                          ((current_state == RX_IDLE) && !sp_pkt && !lp_hdr_pkt));
   assign fifo_rd_norm = !fifo_empty && rx_consumes(next_state);
   assign fifo_rd      = fifo_rd_norm || fifo_rd_junk;

   always_ff @(posedge fifo_rdclk or negedge fifo_rdclk_rst_n) begin
      if (!fifo_rdclk_rst_n) begin
         video_data_vld <= 1'b0;
         video_data     <= '0;
      end else begin
         video_data_vld <= fifo_rd && !fifo_rd_junk;
         if (fifo_rd && !fifo_rd_junk) begin
            video_data <= fifo_rdata;
         end
      end
   end

   assign ack_pre  = (current_state == RX_SILENT) && up_state;
   assign line_end = (current_state == RX_LINE_END);

   always_ff @(posedge fifo_rdclk or negedge fifo_rdclk_rst_n) begin
      if (!fifo_rdclk_rst_n) begin
         ack <= 1'b0;
      end else begin
         ack <= ack_pre;
      end
   end

   // one-hot strobe to the addressed aggregator, out of range ids give none
   always_comb begin
      for (int i = 0; i < `VIDEO_AGGR_NUM; i++) begin
         ack_vld_aggregator[i] = ack && pkt_aggr_id_vld && (pkt_aggr_id == 4'(i));
      end
   end

   a_ack_single : assert property (@(posedge fifo_rdclk) disable iff (!fifo_rdclk_rst_n)
      ack |=> !ack);

endmodule

`default_nettype wire

// File: rtl/video_line_crc_chk.sv
// crc-32 lane check, accumulates long packet payload and flags a bad line crc word
`timescale 1ns/1ps
`default_nettype none

`include "video_rx_cfg.svh"

module video_line_crc_chk (
   input  logic                        fifo_rdclk,
   input  logic                        fifo_rdclk_rst_n,
   input  logic [`VIDEO_DATA_SIZE-1:0] video_data,
   input  logic                        video_data_vld,
   output logic                        crc_err
);

   import video_pkt_pkg::*;

   // 0x04C11DB7 bit reversed
   localparam logic [31:0] CRC_POLY_REF = 32'hEDB88320;

   pkt_flag_t   flags;
   logic        hdr_word;
   logic        data_word;
   logic        crc_word;
   logic [31:0] crc_acc;
   logic [31:0] crc_next;

   // lsb byte first, lsb first within each byte, so just bit order 0..n-1
   function automatic logic [31:0] crc32_step(input logic [31:0]                 crc_in,
                                              input logic [`VIDEO_PAYLOAD_W-1:0] data);
      logic [31:0] crc;
      crc = crc_in;
      for (int i = 0; i < `VIDEO_PAYLOAD_W; i++) begin
         if (crc[0] ^ data[i]) begin
            crc = (crc >> 1) ^ CRC_POLY_REF;
         end else begin
            crc = crc >> 1;
         end
      end
      return crc;
   endfunction

   assign flags     = pkt_flags(video_data);
   assign hdr_word  = video_data_vld && (flags == FLAGS_HEADER);
   assign data_word = video_data_vld && (flags == FLAGS_DATA);
   assign crc_word  = video_data_vld && (flags == FLAGS_CRC);

   assign crc_next  = crc32_step(crc_acc, pkt_payload(video_data));

   always_ff @(posedge fifo_rdclk or negedge fifo_rdclk_rst_n) begin
      if (!fifo_rdclk_rst_n) begin
         crc_acc <= '1;
      end else if (hdr_word) begin
         crc_acc <= '1;
      end else if (data_word) begin
         crc_acc <= crc_next;
      end
   end

   // final inversion before the compare
   always_ff @(posedge fifo_rdclk or negedge fifo_rdclk_rst_n) begin
      if (!fifo_rdclk_rst_n) begin
         crc_err <= 1'b0;
      end else begin
         crc_err <= crc_word && (~crc_acc != pkt_lcrc(video_data));
      end
   end

endmodule

`default_nettype wire

// File: rtl/video_rx_pipe_top.sv
// receive pipe top, line fifo into the packet read controller and the line crc check
`timescale 1ns/1ps
`default_nettype none

`include "video_rx_cfg.svh"

module video_rx_pipe_top (
   input  logic                          fifo_rdclk,
   input  logic                          fifo_rdclk_rst_n,
   input  logic                          wr_en,
   input  logic [`VIDEO_DATA_SIZE-1:0]   wr_data,
   input  logic                          up_state,
   input  logic                          pipe_mem_clear,
   input  logic [3:0]                    pkt_aggr_id,
   input  logic                          pkt_aggr_id_vld,
   input  logic                          empty_depend_cnt_mux,
   input  logic                          pkt_crc_gen_dis,
   input  logic                          sram_lcrc_err_oen,
   output logic                          ack,
   output logic                          ack_pre,
   output logic [`VIDEO_AGGR_NUM-1:0]    ack_vld_aggregator,
   output logic                          line_end,
   output logic [`VIDEO_DATA_SIZE-1:0]   video_data,
   output logic                          video_data_vld,
   output video_rx_ctrl_pkg::rx_state_e  current_state,
   output logic                          sram_lcrc_err,
   output logic                          fifo_full
);

   logic                        fifo_rd;
   logic                        fifo_empty;
   logic [`VIDEO_DATA_SIZE-1:0] fifo_rdata;
   logic                        crc_err;

   video_line_fifo u_fifo (
      .fifo_rdclk       (fifo_rdclk),
      .fifo_rdclk_rst_n (fifo_rdclk_rst_n),
      .wr_en            (wr_en),
      .wr_data          (wr_data),
      .rd_en            (fifo_rd),
      .rdata            (fifo_rdata),
      .empty            (fifo_empty),
      .full             (fifo_full)
   );

   video_fifo_rd_ctrl u_rd_ctrl (
      .fifo_rdclk           (fifo_rdclk),
      .fifo_rdclk_rst_n     (fifo_rdclk_rst_n),
      .up_state             (up_state),
      .fifo_empty           (fifo_empty),
      .fifo_rdata           (fifo_rdata),
      .empty_depend_cnt_mux (empty_depend_cnt_mux),
      .pkt_crc_gen_dis      (pkt_crc_gen_dis),
      .pipe_mem_clear       (pipe_mem_clear),
      .pkt_aggr_id          (pkt_aggr_id),
      .pkt_aggr_id_vld      (pkt_aggr_id_vld),
      .fifo_rd              (fifo_rd),
      .video_data           (video_data),
      .video_data_vld       (video_data_vld),
      .current_state        (current_state),
      .ack                  (ack),
      .ack_pre              (ack_pre),
      .ack_vld_aggregator   (ack_vld_aggregator),
      .line_end             (line_end)
   );

   video_line_crc_chk u_crc_chk (
      .fifo_rdclk       (fifo_rdclk),
      .fifo_rdclk_rst_n (fifo_rdclk_rst_n),
      .video_data       (video_data),
      .video_data_vld   (video_data_vld),
      .crc_err          (crc_err)
   );

   // error reporting enable
   assign sram_lcrc_err = crc_err && sram_lcrc_err_oen;

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
// clock and reset source for the receive pipe testbench, instantiated by the testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS  = 10,
   parameter int RST_CYCLES = 16
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2.0);
         clk = ~clk;
      end
   end

   // release just after an edge
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: testbench/video_rx_pipe_tb.sv
// table-driven testbench for the receive pipe, the simulation top that drives video_rx_pipe_top
`timescale 1ns/1ps
`default_nettype none

`include "video_rx_cfg.svh"

module video_rx_pipe_tb;

   import video_pkt_pkg::*;
   import video_rx_ctrl_pkg::*;

   localparam int     W          = `VIDEO_DATA_SIZE;
   localparam int     FIFO_DEPTH = 1 << `VIDEO_FIFO_AW;
   localparam int     NUM_ROWS   = 11;
   localparam longint TIMEOUT_NS = (NUM_ROWS * 300 + 100) * 10;

   localparam int K_SHORT = 0;
   localparam int K_LONG  = 1;
   localparam int K_NOCRC = 2;
   localparam int K_FLUSH = 3;

   localparam logic [3:0] F_DATA   = 4'b1000;
   localparam logic [3:0] F_SHORT  = 4'b0100;
   localparam logic [3:0] F_FOOTER = 4'b0010;
   localparam logic [3:0] F_HEADER = 4'b0001;

   localparam int C_KIND  = 0;
   localparam int C_MUX   = 1;
   localparam int C_CDIS  = 2;
   localparam int C_OEN   = 3;
   localparam int C_ID    = 4;
   localparam int C_VLD   = 5;
   localparam int C_NDATA = 6;
   localparam int C_BAD   = 7;
   localparam int C_JUNK  = 8;

   // kind, mux, crc_dis, oen, aggr id, id valid, data words, bad crc, junk words
   int tbl [NUM_ROWS][9] = '{
      '{K_SHORT, 1, 0, 1, 0, 1, 0, 0, 0},
      '{K_LONG,  0, 0, 1, 1, 1, 3, 0, 0},
      '{K_LONG,  0, 0, 1, 2, 1, 4, 1, 2},
      '{K_LONG,  0, 0, 0, 3, 1, 2, 1, 1},
      '{K_SHORT, 0, 0, 1, 5, 1, 0, 0, 1},
      '{K_NOCRC, 0, 1, 1, 0, 1, 3, 0, 0},
      '{K_FLUSH, 0, 0, 1, 0, 0, 16, 0, 0},
      '{K_SHORT, 1, 0, 1, 2, 0, 0, 0, 3},
      '{K_LONG,  1, 0, 1, 0, 1, 8, 0, 1},
      '{K_NOCRC, 0, 1, 1, 1, 1, 1, 0, 2},
      '{K_LONG,  0, 0, 1, 3, 1, 0, 0, 0}
   };

   logic                       fifo_rdclk;
   logic                       fifo_rdclk_rst_n;
   logic                       wr_en;
   logic [W-1:0]               wr_data;
   logic                       up_state;
   logic                       pipe_mem_clear;
   logic [3:0]                 pkt_aggr_id;
   logic                       pkt_aggr_id_vld;
   logic                       empty_depend_cnt_mux;
   logic                       pkt_crc_gen_dis;
   logic                       sram_lcrc_err_oen;
   logic                       ack;
   logic                       ack_pre;
   logic [`VIDEO_AGGR_NUM-1:0] ack_vld_aggregator;
   logic                       line_end;
   logic [W-1:0]               video_data;
   logic                       video_data_vld;
   rx_state_e                  current_state;
   logic                       sram_lcrc_err;
   logic                       fifo_full;

   logic [W-1:0]               exp_q [$];
   logic [W-1:0]               wr_q [$];
   logic [3:0]                 exp_aggr = 4'h0;
   // FSM waits for up_state after reset and after every line end
   logic                       asleep = 1'b1;
   int                         errors = 0;
   int                         words_checked = 0;
   int                         ack_cnt = 0;
   int                         line_end_cnt = 0;
   int                         err_cnt = 0;

   tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(16)) u_clk_gen (
      .clk   (fifo_rdclk),
      .rst_n (fifo_rdclk_rst_n)
   );

   video_rx_pipe_top dut (.*);

   function automatic logic [127:0] rand_body();
      return {$urandom, $urandom, $urandom, $urandom};
   endfunction

   function automatic logic [W-1:0] build_word(input logic [3:0] flags, input logic [127:0] body);
      logic [W-1:0] w;
      w = '0;
      w[`VIDEO_PAYLOAD_W-1:0] = body;
      w[`VIDEO_FLAG_MSB:`VIDEO_FLAG_LSB] = flags;
      return w;
   endfunction

   // header and short words carry a data type
   function automatic logic [W-1:0] build_typed(input logic [3:0] flags, input logic [5:0] dt);
      logic [W-1:0] w;
      w = build_word(flags, rand_body());
      w[`VIDEO_DT_MSB:`VIDEO_DT_LSB] = dt;
      w[`VIDEO_SHORT_BIT] = (flags == F_SHORT);
      return w;
   endfunction

   // reflected crc-32, one byte at a time from the low byte up
   function automatic logic [31:0] crc32_ref(input logic [31:0] crc_in, input logic [127:0] body);
      logic [31:0] c;
      c = crc_in;
      for (int b = 0; b < 16; b++) begin
         c = c ^ {24'h0, body[b*8 +: 8]};
         for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
         end
      end
      return c;
   endfunction

   task automatic check_eq(input string name, input logic [W-1:0] expected,
                           input logic [W-1:0] actual);
      assert (actual === expected) else begin
         errors++;
         $display("CHECK FAILED time=%0t %s expected=%0h actual=%0h",
                  $time, name, expected, actual);
      end
   endtask

   task automatic step();
      @(posedge fifo_rdclk);
      #1;
   endtask

   task automatic push_word(input logic [W-1:0] w, input logic shown);
      wr_q.push_back(w);
      if (shown) begin
         exp_q.push_back(w);
      end
   endtask

   task automatic build_packet(input int r);
      logic [W-1:0] w;
      logic [31:0]  crc;
      int           kind;
      kind = tbl[r][C_KIND];
      wr_q.delete();
      // neither a data word nor a non-sync short type may start a packet
      for (int j = 0; j < tbl[r][C_JUNK]; j++) begin
         push_word((j % 2 == 0) ? build_word(F_DATA, rand_body())
                                : build_typed(F_SHORT, RAW8), 0);
      end
      if (kind == K_SHORT) begin
         push_word(build_typed(F_SHORT, 6'(r % 4)), 1);
      end else if (kind == K_FLUSH) begin
         for (int j = 0; j < tbl[r][C_NDATA]; j++) begin
            push_word((j % 2 == 0) ? build_typed(F_HEADER, RAW8) : build_word(F_DATA, rand_body()),
                      0);
         end
      end else begin
         push_word(build_typed(F_HEADER, RAW8), 1);
         crc = 32'hFFFF_FFFF;
         for (int j = 0; j < tbl[r][C_NDATA]; j++) begin
            w = build_word(F_DATA, rand_body());
            crc = crc32_ref(crc, w[127:0]);
            push_word(w, 1);
         end
         push_word(build_word(F_FOOTER, rand_body()), 1);
         if (kind == K_LONG) begin
            w = build_word(4'b0000, rand_body());
            w[31:0] = ~crc ^ ((tbl[r][C_BAD] != 0) ? 32'h0000_0100 : 32'h0);
            push_word(w, 1);
         end
      end
   endtask

   task automatic run_row(input int r);
      int        kind;
      logic      woke;
      rx_state_e end_state;
      kind = tbl[r][C_KIND];
      empty_depend_cnt_mux = (tbl[r][C_MUX] != 0);
      pkt_crc_gen_dis      = (tbl[r][C_CDIS] != 0);
      sram_lcrc_err_oen    = (tbl[r][C_OEN] != 0);
      pkt_aggr_id          = 4'(tbl[r][C_ID]);
      pkt_aggr_id_vld      = (tbl[r][C_VLD] != 0);
      exp_aggr = (pkt_aggr_id_vld && tbl[r][C_ID] < `VIDEO_AGGR_NUM) ?
                 4'(1 << tbl[r][C_ID]) : 4'h0;
      ack_cnt      = 0;
      line_end_cnt = 0;
      err_cnt      = 0;
      woke         = 1'b0;
      build_packet(r);
      foreach (wr_q[i]) begin
         wr_en   = 1'b1;
         wr_data = wr_q[i];
         step();
      end
      wr_en = 1'b0;
      if (kind == K_FLUSH) begin
         // FSM sits in silent here, so every written word is still held
         check_eq("fifo_full", (wr_q.size() >= FIFO_DEPTH), fifo_full);
         pipe_mem_clear = 1'b1;
         repeat (wr_q.size() + 2) step();
         pipe_mem_clear = 1'b0;
         check_eq("fifo_full", 0, fifo_full);
      end else begin
         // a short packet without line end leaves the FSM idle, so no wake-up is due
         if (asleep) begin
            check_eq("current_state", RX_SILENT, current_state);
            up_state = 1'b1;
            woke     = 1'b1;
            @(negedge fifo_rdclk);
            check_eq("ack_pre", 1, ack_pre);
            step();
            up_state = 1'b0;
         end
         end_state = (kind == K_SHORT && !empty_depend_cnt_mux) ? RX_IDLE : RX_SILENT;
         while (exp_q.size() != 0 || current_state != end_state) begin
            step();
         end
         asleep = (end_state == RX_SILENT);
      end
      step();
      check_eq("ack pulses", woke, ack_cnt);
      check_eq("line_end pulses",
               (kind == K_LONG || kind == K_NOCRC || (kind == K_SHORT && empty_depend_cnt_mux)),
               line_end_cnt);
      check_eq("sram_lcrc_err pulses",
               (kind == K_LONG && tbl[r][C_BAD] != 0 && sram_lcrc_err_oen), err_cnt);
   endtask

   always @(negedge fifo_rdclk) begin
      if (fifo_rdclk_rst_n) begin
         if (video_data_vld) begin
            assert (exp_q.size() != 0) else begin
               errors++;
               $display("a word left on video_data at %0t while none was expected: %0h",
                        $time, video_data);
            end
            if (exp_q.size() != 0) begin
               check_eq("video_data", exp_q.pop_front(), video_data);
               words_checked++;
            end
         end
         if (ack) begin
            ack_cnt++;
            check_eq("ack_vld_aggregator", exp_aggr, ack_vld_aggregator);
         end else begin
            check_eq("ack_vld_aggregator", '0, ack_vld_aggregator);
         end
         if (line_end) begin
            line_end_cnt++;
         end
         if (sram_lcrc_err) begin
            err_cnt++;
         end
      end
   end

   initial begin
      wr_en                = 1'b0;
      wr_data              = '0;
      up_state             = 1'b0;
      pipe_mem_clear       = 1'b0;
      pkt_aggr_id          = 4'h0;
      pkt_aggr_id_vld      = 1'b0;
      empty_depend_cnt_mux = 1'b0;
      pkt_crc_gen_dis      = 1'b0;
      sram_lcrc_err_oen    = 1'b0;
      void'($urandom(32'h7150));
      wait (fifo_rdclk_rst_n === 1'b1);
      @(negedge fifo_rdclk);
      check_eq("current_state", RX_SILENT, current_state);
      check_eq("video_data", '0, video_data);
      check_eq("video_data_vld", 0, video_data_vld);
      check_eq("ack", 0, ack);
      check_eq("line_end", 0, line_end);
      check_eq("sram_lcrc_err", 0, sram_lcrc_err);
      step();
      for (int r = 0; r < NUM_ROWS; r++) begin
         run_row(r);
      end
      assert (exp_q.size() == 0) else begin
         errors++;
         $display("%0d expected words never appeared on video_data", exp_q.size());
      end
      $display("rows run: %0d, words checked: %0d, errors: %0d", NUM_ROWS, words_checked, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("watchdog expired at %0t before all rows were done", $time);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: video_rx_pipe.f
+incdir+include
rtl/video_pkt_pkg.sv
rtl/video_rx_ctrl_pkg.sv
rtl/video_line_fifo.sv
rtl/video_fifo_rd_ctrl.sv
rtl/video_line_crc_chk.sv
rtl/video_rx_pipe_top.sv
testbench/tb_clk_gen.sv
testbench/video_rx_pipe_tb.sv

// File: Bender.yml
package:
  name: video_rx_pipe

export_include_dirs:
  - include

sources:
  - files:
      - rtl/video_pkt_pkg.sv
      - rtl/video_rx_ctrl_pkg.sv
      - rtl/video_line_fifo.sv
      - rtl/video_fifo_rd_ctrl.sv
      - rtl/video_line_crc_chk.sv
      - rtl/video_rx_pipe_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/video_rx_pipe_tb.sv
